//--- hw/saturn_alu_pkg.sv
package saturn_alu_pkg;

  // architectural register sizes
  localparam int REG_W       = 64;
  localparam int ST_W        = 16;
  localparam int REG_NIBBLES = REG_W / 4;
  localparam int ST_NIBBLES  = ST_W / 4;

  // one hex or bcd digit
  typedef logic [3:0] nibble_t;

  // nibble index inside a 64-bit register
  typedef logic [3:0] field_t;

  // operations the unit still carries out
  typedef enum logic [3:0] {
    OP_ZERO     = 4'd0,
    OP_COPY     = 4'd1,
    OP_EXCH     = 4'd2,
    OP_ADD      = 4'd3,
    OP_2CMPL    = 4'd4,
    OP_CLR_MASK = 4'd5,
    OP_TEST_EQ  = 4'd6,
    OP_TEST_NEQ = 4'd7,
    OP_SET_BIT  = 4'd8,
    OP_RST_BIT  = 4'd9
  } alu_op_t;

  // operand codes, A to D share the low two bits with their index
  typedef enum logic [2:0] {
    REG_A    = 3'd0,
    REG_B    = 3'd1,
    REG_C    = 3'd2,
    REG_D    = 3'd3,
    REG_ST   = 3'd4,
    REG_IMM  = 3'd5,
    REG_ZERO = 3'd6
  } alu_reg_t;

  // three phases for every nibble of the field
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    PREP = 2'd1,
    CALC = 2'd2,
    SAVE = 2'd3
  } seq_phase_t;

endpackage

//--- hw/saturn_bus_pkg.sv
package saturn_bus_pkg;

  localparam int WB_DATA_W = 32;

  // word address map of the slave
  typedef enum logic [3:0] {
    CMD    = 4'd0,
    A_LO   = 4'd1,
    A_HI   = 4'd2,
    B_LO   = 4'd3,
    B_HI   = 4'd4,
    C_LO   = 4'd5,
    C_HI   = 4'd6,
    D_LO   = 4'd7,
    D_HI   = 4'd8,
    ST_REG = 4'd9,
    FLAGS  = 4'd10
  } wb_addr_t;

  // command word fields, low bit upward
  localparam int CMD_OP_W    = 4;
  localparam int CMD_DEST_W  = 3;
  localparam int CMD_SRC1_W  = 3;
  localparam int CMD_SRC2_W  = 3;
  localparam int CMD_FIRST_W = 4;
  localparam int CMD_LAST_W  = 4;
  localparam int CMD_IMM_W   = 4;

  localparam int CMD_OP_LSB    = 0;
  localparam int CMD_DEST_LSB  = CMD_OP_LSB + CMD_OP_W;
  localparam int CMD_SRC1_LSB  = CMD_DEST_LSB + CMD_DEST_W;
  localparam int CMD_SRC2_LSB  = CMD_SRC1_LSB + CMD_SRC1_W;
  localparam int CMD_FIRST_LSB = CMD_SRC2_LSB + CMD_SRC2_W;
  localparam int CMD_LAST_LSB  = CMD_FIRST_LSB + CMD_FIRST_W;
  localparam int CMD_IMM_LSB   = CMD_LAST_LSB + CMD_LAST_W;

endpackage

//--- hw/wb_cmd_port.sv
`timescale 1ns/100ps

module wb_cmd_port import saturn_alu_pkg::*, saturn_bus_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_wb_cyc,
  input  logic                 i_wb_stb,
  input  logic                 i_wb_we,
  input  wb_addr_t             i_wb_adr,
  input  logic [WB_DATA_W-1:0] i_wb_dat,
  input  logic                 i_done,
  input  logic [WB_DATA_W-1:0] i_bus_rdat,
  output logic                 o_wb_ack,
  output logic [WB_DATA_W-1:0] o_wb_dat,
  output logic                 o_start,
  output alu_op_t              o_op,
  output alu_reg_t             o_dest,
  output alu_reg_t             o_src1,
  output alu_reg_t             o_src2,
  output field_t               o_first,
  output field_t               o_last,
  output nibble_t              o_imm,
  output logic                 o_bus_we,
  output wb_addr_t             o_bus_adr,
  output logic [WB_DATA_W-1:0] o_bus_wdat
);

  typedef enum logic [1:0] {S_IDLE, S_BUSY, S_ACK} port_state_t;

  port_state_t state;
  logic        req;
  logic        busy;

  assign req  = i_wb_cyc && i_wb_stb;
  assign busy = (state == S_BUSY);

  // control path
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state    <= S_IDLE;
      o_wb_ack <= 1'b0;
      o_start  <= 1'b0;
      o_bus_we <= 1'b0;
    end else begin
      // single cycle pulses by default
      o_wb_ack <= 1'b0;
      o_start  <= 1'b0;
      o_bus_we <= 1'b0;
      case (state)
        S_IDLE: begin
          if (req && i_wb_we && i_wb_adr == CMD) begin
            // command word, kick off the sequencer
            o_start <= 1'b1;
            state   <= S_BUSY;
          end else if (req) begin
            // plain register access, acked next cycle
            o_wb_ack <= 1'b1;
            o_bus_we <= i_wb_we;
            state    <= S_ACK;
          end
        end
        S_BUSY: begin
          // accesses wait here until the command is through
          if (i_done) begin
            o_wb_ack <= 1'b1;
            state    <= S_ACK;
          end
        end
        default: begin
          // master drops stb after this cycle
          state <= S_IDLE;
        end
      endcase
    end
  end

  // command fields and bus word, stable while busy
  always_ff @(posedge i_clk) begin
    if (state == S_IDLE && req) begin
      o_bus_adr  <= i_wb_adr;
      o_bus_wdat <= i_wb_dat;
      if (i_wb_we && i_wb_adr == CMD) begin
        o_op    <= alu_op_t'(i_wb_dat[CMD_OP_LSB +: CMD_OP_W]);
        o_dest  <= alu_reg_t'(i_wb_dat[CMD_DEST_LSB +: CMD_DEST_W]);
        o_src1  <= alu_reg_t'(i_wb_dat[CMD_SRC1_LSB +: CMD_SRC1_W]);
        o_src2  <= alu_reg_t'(i_wb_dat[CMD_SRC2_LSB +: CMD_SRC2_W]);
        o_first <= i_wb_dat[CMD_FIRST_LSB +: CMD_FIRST_W];
        o_last  <= i_wb_dat[CMD_LAST_LSB +: CMD_LAST_W];
        o_imm   <= i_wb_dat[CMD_IMM_LSB +: CMD_IMM_W];
      end
    end
  end

  // read data, busy goes into bit 1 of flags
  always_comb begin
    o_wb_dat = i_bus_rdat;
    if (o_bus_adr == FLAGS) begin
      o_wb_dat[1] = busy;
    end
  end

  // no ack may slip out while a command runs
  a_no_ack_busy: assert property (@(posedge i_clk) disable iff (i_reset)
    busy |-> !o_wb_ack);

  // done from the sequencer is answered by the command ack
  a_done_ack: assert property (@(posedge i_clk) disable iff (i_reset)
    i_done |-> busy ##1 o_wb_ack);

endmodule

//--- hw/nibble_sequencer.sv
`timescale 1ns/100ps

module nibble_sequencer import saturn_alu_pkg::*; (
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_start,
  input  field_t     i_first,
  input  field_t     i_last,
  output seq_phase_t o_phase,
  output field_t     o_f_cur,
  output logic       o_first_nib,
  output logic       o_last_nib,
  output logic       o_done
);

  // first and last are held by the port for the whole command
  assign o_first_nib = (o_f_cur == i_first);
  assign o_last_nib  = (o_f_cur == i_last);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_phase <= IDLE;
      o_f_cur <= '0;
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (o_phase)
        IDLE: begin
          if (i_start) begin
            o_phase <= PREP;
            o_f_cur <= i_first;
          end
        end
        PREP: o_phase <= CALC;
        CALC: o_phase <= SAVE;
        default: begin
          // next nibble, wraps from 15 to 0
          o_f_cur <= o_f_cur + 4'd1;
          if (o_last_nib) begin
            o_phase <= IDLE;
            o_done  <= 1'b1;
          end else begin
            o_phase <= PREP;
          end
        end
      endcase
    end
  end

  // prep, calc and save always come as a group
  a_phase_order: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_phase == PREP) |=> (o_phase == CALC) ##1 (o_phase == SAVE));

endmodule

//--- hw/nibble_datapath.sv
`timescale 1ns/100ps

module nibble_datapath import saturn_alu_pkg::*; (
  input  logic       i_clk,
  input  logic       i_reset,
  input  seq_phase_t i_phase,
  input  logic       i_first_nib,
  input  logic       i_last_nib,
  input  alu_op_t    i_op,
  input  alu_reg_t   i_dest,
  input  alu_reg_t   i_src1,
  input  alu_reg_t   i_src2,
  input  nibble_t    i_imm,
  input  nibble_t    i_rd_nib1,
  input  nibble_t    i_rd_nib2,
  output alu_reg_t   o_rd_sel1,
  output alu_reg_t   o_rd_sel2,
  output logic       o_wr_en1,
  output alu_reg_t   o_wr_sel1,
  output nibble_t    o_wr_nib1,
  output logic       o_wr_en2,
  output alu_reg_t   o_wr_sel2,
  output nibble_t    o_wr_nib2,
  output logic       o_st_bit_en,
  output nibble_t    o_st_bit_idx,
  output logic       o_st_bit_val,
  output logic       o_carry_en,
  output logic       o_carry_val
);

  nibble_t p_src1, p_src2, c_res1, c_res2;
  logic    p_carry, c_carry;
  // running flags over the field
  logic    neq_acc, nz_acc;
  logic    is_save;
  // nibble adder, carry out in bit 4
  logic [4:0] sum;

  assign o_rd_sel1 = i_src1;
  assign o_rd_sel2 = i_src2;
  assign is_save   = (i_phase == SAVE);

  // negate adds the carry to the inverted source
  always_comb begin
    if (i_op == OP_2CMPL) sum = {1'b0, ~p_src1} + {4'h0, p_carry};
    else sum = {1'b0, p_src1} + {1'b0, p_src2} + {4'h0, p_carry};
  end

  // operand latch, imm and zero never touch the register file
  always_ff @(posedge i_clk) begin
    if (i_phase == PREP) begin
      p_src1 <= (i_src1 == REG_IMM) ? i_imm : (i_src1 == REG_ZERO) ? 4'h0 : i_rd_nib1;
      p_src2 <= (i_src2 == REG_IMM) ? i_imm : (i_src2 == REG_ZERO) ? 4'h0 : i_rd_nib2;
    end
    if (i_phase == CALC) begin
      c_res2 <= p_src1;
      case (i_op)
        OP_ZERO:          c_res1 <= 4'h0;
        OP_EXCH:          c_res1 <= p_src2;
        OP_ADD, OP_2CMPL: c_res1 <= sum[3:0];
        OP_CLR_MASK:      c_res1 <= p_src1 & ~p_src2;
        default:          c_res1 <= p_src1;
      endcase
    end
  end

  // carry chain and field flags
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      p_carry <= 1'b0;
      c_carry <= 1'b0;
      neq_acc <= 1'b0;
      nz_acc  <= 1'b0;
    end else begin
      if (i_phase == PREP) begin
        // 2's complement adds one at the first nibble
        if (i_first_nib) p_carry <= (i_op == OP_2CMPL);
        else p_carry <= c_carry;
      end
      if (i_phase == CALC) begin
        neq_acc <= (p_src1 != p_src2) || (!i_first_nib && neq_acc);
        nz_acc  <= (p_src1 != 4'h0) || (!i_first_nib && nz_acc);
        case (i_op)
          OP_ADD, OP_2CMPL: c_carry <= sum[4];
          default:          c_carry <= p_carry;
        endcase
      end
    end
  end

  // write back
  assign o_wr_en1  = is_save && (i_op inside {OP_ZERO, OP_COPY, OP_EXCH, OP_ADD,
                                              OP_2CMPL, OP_CLR_MASK});
  assign o_wr_sel1 = i_dest;
  assign o_wr_nib1 = c_res1;
  // exchange also writes the old dest nibble into src2
  assign o_wr_en2  = is_save && (i_op == OP_EXCH);
  assign o_wr_sel2 = i_src2;
  assign o_wr_nib2 = c_res2;

  // st bit picked by the immediate, once per command
  assign o_st_bit_en  = is_save && i_last_nib && (i_op inside {OP_SET_BIT, OP_RST_BIT});
  assign o_st_bit_idx = i_imm;
  assign o_st_bit_val = (i_op == OP_SET_BIT);

  assign o_carry_en = is_save && i_last_nib &&
                      (i_op inside {OP_ADD, OP_2CMPL, OP_TEST_EQ, OP_TEST_NEQ});
  always_comb begin
    case (i_op)
      OP_2CMPL:    o_carry_val = nz_acc;
      OP_TEST_EQ:  o_carry_val = !neq_acc;
      OP_TEST_NEQ: o_carry_val = neq_acc;
      default:     o_carry_val = c_carry;
    endcase
  end

  // writes only land in save, straight after calc
  a_wr_in_save: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_wr_en1 || o_wr_en2) |-> is_save && ($past(i_phase) == CALC));

endmodule

//--- hw/working_regs.sv
`timescale 1ns/100ps

module working_regs import saturn_alu_pkg::*, saturn_bus_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  field_t               i_f_cur,
  input  alu_reg_t             i_rd_sel1,
  input  alu_reg_t             i_rd_sel2,
  input  logic                 i_wr_en1,
  input  alu_reg_t             i_wr_sel1,
  input  nibble_t              i_wr_nib1,
  input  logic                 i_wr_en2,
  input  alu_reg_t             i_wr_sel2,
  input  nibble_t              i_wr_nib2,
  input  logic                 i_st_bit_en,
  input  nibble_t              i_st_bit_idx,
  input  logic                 i_st_bit_val,
  input  logic                 i_carry_en,
  input  logic                 i_carry_val,
  input  logic                 i_bus_we,
  input  wb_addr_t             i_bus_adr,
  input  logic [WB_DATA_W-1:0] i_bus_wdat,
  output nibble_t              o_rd_nib1,
  output nibble_t              o_rd_nib2,
  output logic [WB_DATA_W-1:0] o_bus_rdat
);

  // A to D, indexed by the low bits of the operand code
  logic [REG_W-1:0] gpr [4];
  logic [ST_W-1:0]  st;
  logic             carry;
  logic [REG_W-1:0] st_ext;
  logic [5:0]       nib_lsb;
  logic [3:0]       word_idx;
  logic             bus_gpr;
  logic [1:0]       wr_en;
  alu_reg_t         wr_sel [2];
  nibble_t          wr_nib [2];

  // upper st nibbles read as zero
  assign st_ext   = {{(REG_W - ST_W){1'b0}}, st};
  assign nib_lsb  = {i_f_cur, 2'b00};
  // A_LO is word 0 of the register block
  assign word_idx = i_bus_adr - 4'd1;
  assign bus_gpr  = i_bus_adr inside {[A_LO:D_HI]};

  assign wr_en     = {i_wr_en2, i_wr_en1};
  assign wr_sel[0] = i_wr_sel1;
  assign wr_sel[1] = i_wr_sel2;
  assign wr_nib[0] = i_wr_nib1;
  assign wr_nib[1] = i_wr_nib2;

  function automatic nibble_t rd_nib(input alu_reg_t sel, input logic [REG_W-1:0] gpr_w,
                                     input logic [REG_W-1:0] st_w, input logic [5:0] lsb);
    nibble_t val;
    val = 4'h0;
    if (sel == REG_ST) val = st_w[lsb +: 4];
    else if (sel inside {REG_A, REG_B, REG_C, REG_D}) val = gpr_w[lsb +: 4];
    return val;
  endfunction

  // nibble reads at f_cur
  always_comb begin
    o_rd_nib1 = rd_nib(i_rd_sel1, gpr[i_rd_sel1[1:0]], st_ext, nib_lsb);
    o_rd_nib2 = rd_nib(i_rd_sel2, gpr[i_rd_sel2[1:0]], st_ext, nib_lsb);
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int r = 0; r < 4; r++) begin
        gpr[r] <= '0;
      end
      st    <= '0;
      carry <= 1'b0;
    end else begin
      // nibble writes from the datapath
      for (int p = 0; p < 2; p++) begin
        if (wr_en[p]) begin
          if (wr_sel[p] == REG_ST) begin
            // st has only four nibbles
            if (i_f_cur < ST_NIBBLES) st[{i_f_cur[1:0], 2'b00} +: 4] <= wr_nib[p];
          end else if (wr_sel[p] inside {REG_A, REG_B, REG_C, REG_D}) begin
            gpr[wr_sel[p][1:0]][nib_lsb +: 4] <= wr_nib[p];
          end
        end
      end
      if (i_st_bit_en) st[i_st_bit_idx] <= i_st_bit_val;
      if (i_carry_en) carry <= i_carry_val;
      // bus word writes, only while idle
      if (i_bus_we) begin
        if (bus_gpr) gpr[word_idx[2:1]][word_idx[0]*WB_DATA_W +: WB_DATA_W] <= i_bus_wdat;
        else if (i_bus_adr == ST_REG) st <= i_bus_wdat[ST_W-1:0];
        else if (i_bus_adr == FLAGS) carry <= i_bus_wdat[0];
      end
    end
  end

  // bus word reads
  always_comb begin
    o_bus_rdat = '0;
    if (bus_gpr) o_bus_rdat = gpr[word_idx[2:1]][word_idx[0]*WB_DATA_W +: WB_DATA_W];
    else if (i_bus_adr == ST_REG) o_bus_rdat[ST_W-1:0] = st;
    else if (i_bus_adr == FLAGS) o_bus_rdat[0] = carry;
  end

  // bus and datapath never write in the same cycle
  a_one_writer: assert property (@(posedge i_clk) disable iff (i_reset)
    i_bus_we |-> !(i_wr_en1 || i_wr_en2 || i_st_bit_en || i_carry_en));

endmodule

//--- hw/saturn_alu_top.sv
`timescale 1ns/100ps

module saturn_alu_top import saturn_alu_pkg::*, saturn_bus_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_wb_cyc,
  input  logic                 i_wb_stb,
  input  logic                 i_wb_we,
  input  wb_addr_t             i_wb_adr,
  input  logic [WB_DATA_W-1:0] i_wb_dat,
  output logic                 o_wb_ack,
  output logic [WB_DATA_W-1:0] o_wb_dat
);

  // port to sequencer
  logic       start, done;
  alu_op_t    op;
  alu_reg_t   dest, src1, src2;
  field_t     first, last;
  nibble_t    imm;
  // sequencer outputs
  seq_phase_t phase;
  field_t     f_cur;
  logic       first_nib, last_nib;
  // datapath to registers
  alu_reg_t   rd_sel1, rd_sel2, wr_sel1, wr_sel2;
  nibble_t    rd_nib1, rd_nib2, wr_nib1, wr_nib2, st_bit_idx;
  logic       wr_en1, wr_en2, st_bit_en, st_bit_val, carry_en, carry_val;
  // bus word access
  logic                 bus_we;
  wb_addr_t             bus_adr;
  logic [WB_DATA_W-1:0] bus_wdat, bus_rdat;

  wb_cmd_port u_port (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
    .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .i_done(done), .i_bus_rdat(bus_rdat),
    .o_wb_ack(o_wb_ack), .o_wb_dat(o_wb_dat), .o_start(start), .o_op(op),
    .o_dest(dest), .o_src1(src1), .o_src2(src2), .o_first(first), .o_last(last),
    .o_imm(imm), .o_bus_we(bus_we), .o_bus_adr(bus_adr), .o_bus_wdat(bus_wdat)
  );

  nibble_sequencer u_seq (
    .i_clk(i_clk), .i_reset(i_reset), .i_start(start), .i_first(first), .i_last(last),
    .o_phase(phase), .o_f_cur(f_cur), .o_first_nib(first_nib), .o_last_nib(last_nib),
    .o_done(done)
  );

  nibble_datapath u_dp (
    .i_clk(i_clk), .i_reset(i_reset), .i_phase(phase), .i_first_nib(first_nib),
    .i_last_nib(last_nib), .i_op(op), .i_dest(dest), .i_src1(src1), .i_src2(src2),
    .i_imm(imm), .i_rd_nib1(rd_nib1), .i_rd_nib2(rd_nib2),
    .o_rd_sel1(rd_sel1), .o_rd_sel2(rd_sel2),
    .o_wr_en1(wr_en1), .o_wr_sel1(wr_sel1), .o_wr_nib1(wr_nib1),
    .o_wr_en2(wr_en2), .o_wr_sel2(wr_sel2), .o_wr_nib2(wr_nib2),
    .o_st_bit_en(st_bit_en), .o_st_bit_idx(st_bit_idx), .o_st_bit_val(st_bit_val),
    .o_carry_en(carry_en), .o_carry_val(carry_val)
  );

  working_regs u_regs (
    .i_clk(i_clk), .i_reset(i_reset), .i_f_cur(f_cur),
    .i_rd_sel1(rd_sel1), .i_rd_sel2(rd_sel2),
    .i_wr_en1(wr_en1), .i_wr_sel1(wr_sel1), .i_wr_nib1(wr_nib1),
    .i_wr_en2(wr_en2), .i_wr_sel2(wr_sel2), .i_wr_nib2(wr_nib2),
    .i_st_bit_en(st_bit_en), .i_st_bit_idx(st_bit_idx), .i_st_bit_val(st_bit_val),
    .i_carry_en(carry_en), .i_carry_val(carry_val),
    .i_bus_we(bus_we), .i_bus_adr(bus_adr), .i_bus_wdat(bus_wdat),
    .o_rd_nib1(rd_nib1), .o_rd_nib2(rd_nib2), .o_bus_rdat(bus_rdat)
  );

endmodule

//--- test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// nibble of an operand as the instruction set defines it
function automatic nibble_t ref_get(input alu_reg_t r, input int idx, input nibble_t imm);
  nibble_t v;
  v = 4'h0;
  case (r)
    REG_A, REG_B, REG_C, REG_D: v = m_gpr[int'(r)][idx*4 +: 4];
    // st is only four nibbles wide, the rest reads as zero
    REG_ST: if (idx < ST_NIBBLES) v = m_st[idx*4 +: 4];
    REG_IMM: v = imm;
    default: v = 4'h0;
  endcase
  return v;
endfunction

function automatic void ref_put(input alu_reg_t r, input int idx, input nibble_t v);
  case (r)
    REG_A, REG_B, REG_C, REG_D: m_gpr[int'(r)][idx*4 +: 4] = v;
    REG_ST: if (idx < ST_NIBBLES) m_st[idx*4 +: 4] = v;
    // imm and zero are no place to store anything
    default: ;
  endcase
endfunction

// one command applied to the model registers
function automatic void ref_apply(input alu_op_t op, input alu_reg_t dest, input alu_reg_t src1,
                                  input alu_reg_t src2, input field_t first, input field_t last,
                                  input nibble_t imm);
  field_t     span;
  int         idx;
  nibble_t    x;
  nibble_t    y;
  logic [4:0] sum;
  logic       cy;
  logic       differ;
  logic       nonzero;
  span    = last - first;
  // negate is invert plus one across the whole field
  cy      = (op == OP_2CMPL);
  differ  = 1'b0;
  nonzero = 1'b0;
  for (int k = 0; k <= int'(span); k++) begin
    idx = (int'(first) + k) % REG_NIBBLES;
    x   = ref_get(src1, idx, imm);
    y   = ref_get(src2, idx, imm);
    if (x != y) differ = 1'b1;
    if (x != 4'h0) nonzero = 1'b1;
    case (op)
      OP_ZERO: ref_put(dest, idx, 4'h0);
      OP_COPY: ref_put(dest, idx, x);
      OP_EXCH: begin
        ref_put(dest, idx, y);
        ref_put(src2, idx, x);
      end
      OP_ADD: begin
        sum = {1'b0, x} + {1'b0, y} + {4'h0, cy};
        ref_put(dest, idx, sum[3:0]);
        cy = sum[4];
      end
      OP_2CMPL: begin
        sum = {1'b0, ~x} + {4'h0, cy};
        ref_put(dest, idx, sum[3:0]);
        cy = sum[4];
      end
      OP_CLR_MASK: ref_put(dest, idx, x & ~y);
      default: ;
    endcase
  end
  case (op)
    OP_ADD:      m_carry = cy;
    OP_2CMPL:    m_carry = nonzero;
    OP_TEST_EQ:  m_carry = !differ;
    OP_TEST_NEQ: m_carry = differ;
    OP_SET_BIT:  m_st[imm] = 1'b1;
    OP_RST_BIT:  m_st[imm] = 1'b0;
    default: ;
  endcase
endfunction

task automatic check_reg(input string name, input logic [REG_W-1:0] exp,
                         input logic [REG_W-1:0] act);
  if (act !== exp) begin
    $display("FAILED %s: expected %016h, actual %016h", name, exp, act);
    err_value++;
  end
endtask

task automatic check_st(input string name, input logic [ST_W-1:0] exp,
                        input logic [ST_W-1:0] act);
  if (act !== exp) begin
    $display("FAILED %s: expected %04h, actual %04h", name, exp, act);
    err_value++;
  end
endtask

// carry and busy flags
task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("FAILED %s: expected %b, actual %b", name, exp, act);
    err_value++;
  end
endtask

// clock edges from the stb sample up to the ack
task automatic check_latency(input string name, input int exp, input int act);
  if (act != exp) begin
    $display("FAILED %s latency: expected %0d, actual %0d", name, exp, act);
    err_value++;
  end
endtask

`endif

//--- test/tb_saturn_alu.sv
`timescale 1ns/100ps

module tb_saturn_alu import saturn_alu_pkg::*, saturn_bus_pkg::*;;

  localparam int ACK_TIMEOUT = 200;

  logic                 clk;
  logic                 reset;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  wb_addr_t             wb_adr;
  logic [WB_DATA_W-1:0] wb_dat_w;
  logic                 wb_ack;
  logic [WB_DATA_W-1:0] wb_dat_r;

  // model copy of the architectural state
  logic [REG_W-1:0] m_gpr [4];
  logic [ST_W-1:0]  m_st;
  logic             m_carry;
  int               err_value;
  int               err_timeout;
  logic [31:0]      lfsr;

  `include "tb_ref_model.svh"

  saturn_alu_top uut (
    .i_clk(clk),
    .i_reset(reset),
    .i_wb_cyc(wb_cyc),
    .i_wb_stb(wb_stb),
    .i_wb_we(wb_we),
    .i_wb_adr(wb_adr),
    .i_wb_dat(wb_dat_w),
    .o_wb_ack(wb_ack),
    .o_wb_dat(wb_dat_r)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step for every bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic nibble_t pick_nib();
    logic [63:0] b;
    b = rand_bits(4);
    return b[3:0];
  endfunction

  function automatic alu_reg_t pick_gpr();
    logic [63:0] b;
    b = rand_bits(2);
    return alu_reg_t'({1'b0, b[1:0]});
  endfunction

  // some register of A to D other than r
  function automatic alu_reg_t pick_other(input alu_reg_t r);
    logic [63:0] b;
    logic [1:0]  k;
    b = rand_bits(2);
    k = b[1:0];
    if (k == r[1:0]) k = k + 2'd1;
    return alu_reg_t'({1'b0, k});
  endfunction

  function automatic logic [31:0] cmd_word(input alu_op_t op, input alu_reg_t dest,
                                           input alu_reg_t src1, input alu_reg_t src2,
                                           input field_t first, input field_t last,
                                           input nibble_t imm);
    logic [31:0] w;
    w = '0;
    w[CMD_OP_LSB +: CMD_OP_W]       = op;
    w[CMD_DEST_LSB +: CMD_DEST_W]   = dest;
    w[CMD_SRC1_LSB +: CMD_SRC1_W]   = src1;
    w[CMD_SRC2_LSB +: CMD_SRC2_W]   = src2;
    w[CMD_FIRST_LSB +: CMD_FIRST_W] = first;
    w[CMD_LAST_LSB +: CMD_LAST_W]   = last;
    w[CMD_IMM_LSB +: CMD_IMM_W]     = imm;
    return w;
  endfunction

  // classic single access, signals held until ack
  task automatic bus_cycle(input logic we, input wb_addr_t adr, input logic [31:0] wdat,
                           output logic [31:0] rdat, output int edges);
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    edges    = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
    end while (!wb_ack && edges < ACK_TIMEOUT);
    if (!wb_ack) begin
      $display("ERROR: no ack within %0d cycles for address %s", ACK_TIMEOUT, adr.name());
      err_timeout++;
    end
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic reg_write(input wb_addr_t adr, input logic [31:0] wdat);
    logic [31:0] rdat;
    int          edges;
    bus_cycle(1'b1, adr, wdat, rdat, edges);
    check_latency($sformatf("write %s", adr.name()), 1, edges);
  endtask

  task automatic reg_read(input wb_addr_t adr, output logic [31:0] rdat);
    int edges;
    bus_cycle(1'b0, adr, '0, rdat, edges);
    check_latency($sformatf("read %s", adr.name()), 1, edges);
  endtask

  task automatic load_gpr(input int r, input logic [63:0] v);
    reg_write(wb_addr_t'(A_LO + 2 * r), v[31:0]);
    reg_write(wb_addr_t'(A_LO + 2 * r + 1), v[63:32]);
    m_gpr[r] = v;
  endtask

  task automatic read_gpr(input int r, output logic [63:0] v);
    logic [31:0] lo;
    logic [31:0] hi;
    reg_read(wb_addr_t'(A_LO + 2 * r), lo);
    reg_read(wb_addr_t'(A_LO + 2 * r + 1), hi);
    v = {hi, lo};
  endtask

  task automatic load_random();
    for (int r = 0; r < 4; r++) begin
      load_gpr(r, rand_bits(64));
    end
  endtask

  task automatic set_carry(input logic c);
    reg_write(FLAGS, {31'd0, c});
    m_carry = c;
  endtask

  // reads every register back and compares with the model
  task automatic check_state(input string name);
    logic [63:0] v;
    logic [31:0] w;
    alu_reg_t    rc;
    for (int r = 0; r < 4; r++) begin
      rc = alu_reg_t'(r);
      read_gpr(r, v);
      check_reg($sformatf("%s %s", name, rc.name()), m_gpr[r], v);
    end
    reg_read(ST_REG, w);
    check_st({name, " ST"}, m_st, w[ST_W-1:0]);
    reg_read(FLAGS, w);
    check_flag({name, " CARRY"}, m_carry, w[0]);
    check_flag({name, " busy"}, 1'b0, w[1]);
  endtask

  task automatic run_cmd(input string name, input alu_op_t op, input alu_reg_t dest,
                         input alu_reg_t src1, input alu_reg_t src2, input field_t first,
                         input field_t last, input nibble_t imm);
    logic [31:0] rdat;
    field_t      span;
    int          edges;
    span = last - first;
    bus_cycle(1'b1, CMD, cmd_word(op, dest, src1, src2, first, last, imm), rdat, edges);
    // three cycles a nibble, plus start and done
    check_latency(name, 3 * (int'(span) + 1) + 3, edges);
    ref_apply(op, dest, src1, src2, first, last, imm);
    check_state(name);
  endtask

  initial begin
    logic [31:0] w;
    logic [63:0] v;
    logic [31:0] rdat;
    int          edges;
    field_t      f1;
    field_t      f2;
    alu_reg_t    ra;
    alu_reg_t    rb;
    alu_reg_t    rc;
    nibble_t     imm;
    clk         = 1'b0;
    reset       = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = CMD;
    wb_dat_w    = '0;
    lfsr        = 32'haeff3cc9;
    err_value   = 0;
    err_timeout = 0;
    for (int r = 0; r < 4; r++) begin
      m_gpr[r] = '0;
    end
    m_st    = '0;
    m_carry = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // reset state, then word writes and read-back
    check_state("after reset");
    load_random();
    w = rand_bits(32);
    reg_write(ST_REG, w);
    m_st = w[ST_W-1:0];
    reg_read(ST_REG, w);
    check_st("st readback", m_st, w[ST_W-1:0]);
    check_st("st upper bits", 16'h0, w[31:16]);
    set_carry(1'b1);
    check_state("readback");

    // zero, copy, exchange over random fields, wrapping ones too
    for (int t = 0; t < 9; t++) begin
      ra = pick_gpr();
      rb = pick_other(ra);
      f1 = pick_nib();
      f2 = pick_nib();
      case (t % 3)
        0: run_cmd("zero", OP_ZERO, ra, ra, ra, f1, f2, 4'h0);
        1: run_cmd("copy", OP_COPY, ra, rb, rb, f1, f2, 4'h0);
        default: run_cmd("exchange", OP_EXCH, ra, ra, rb, f1, f2, 4'h0);
      endcase
    end
    run_cmd("copy wrap", OP_COPY, REG_C, REG_A, REG_A, 4'd14, 4'd1, 4'h0);
    run_cmd("exchange wrap", OP_EXCH, REG_B, REG_B, REG_D, 4'd13, 4'd2, 4'h0);
    // st nibbles above 3 read as zero and ignore writes
    run_cmd("copy from st", OP_COPY, REG_B, REG_ST, REG_ST, 4'd2, 4'd6, 4'h0);
    run_cmd("copy into st", OP_COPY, REG_ST, REG_A, REG_A, 4'd3, 4'd5, 4'h0);

    // add, a stale carry must not leak into the first nibble
    for (int t = 0; t < 8; t++) begin
      if (t % 2 == 0) load_random();
      set_carry(1'b1);
      ra = pick_gpr();
      rb = pick_gpr();
      rc = pick_gpr();
      run_cmd("add", OP_ADD, ra, rb, rc, pick_nib(), pick_nib(), 4'h0);
    end
    load_gpr(0, '1);
    load_gpr(1, 64'h1);
    run_cmd("add carry out", OP_ADD, REG_C, REG_A, REG_B, 4'd0, 4'd15, 4'h0);

    // negate and clear by mask
    load_random();
    for (int t = 0; t < 4; t++) begin
      ra = pick_gpr();
      // nonzero field has to raise a cleared carry
      set_carry(1'b0);
      run_cmd("negate", OP_2CMPL, ra, ra, ra, pick_nib(), pick_nib(), 4'h0);
      rb = pick_gpr();
      imm = pick_nib();
      run_cmd("clear mask", OP_CLR_MASK, rb, rb, REG_IMM, pick_nib(), pick_nib(), imm);
    end
    run_cmd("zero field", OP_ZERO, REG_A, REG_A, REG_A, 4'd3, 4'd9, 4'h0);
    run_cmd("negate zero field", OP_2CMPL, REG_A, REG_A, REG_A, 4'd3, 4'd9, 4'h0);

    // tests on equal and on differing operands
    load_random();
    run_cmd("copy for test", OP_COPY, REG_B, REG_A, REG_A, 4'd4, 4'd11, 4'h0);
    run_cmd("test equal same", OP_TEST_EQ, REG_A, REG_A, REG_B, 4'd4, 4'd11, 4'h0);
    run_cmd("test differ same", OP_TEST_NEQ, REG_A, REG_A, REG_B, 4'd4, 4'd11, 4'h0);
    // carry preset against the expected outcome
    set_carry(1'b1);
    run_cmd("test equal diff", OP_TEST_EQ, REG_C, REG_C, REG_D, 4'd10, 4'd3, 4'h0);
    run_cmd("test differ diff", OP_TEST_NEQ, REG_C, REG_C, REG_D, 4'd10, 4'd3, 4'h0);
    imm = m_gpr[0][3:0];
    set_carry(1'b0);
    run_cmd("test equal imm", OP_TEST_EQ, REG_A, REG_A, REG_IMM, 4'd0, 4'd0, imm);
    // one st bit picked by the immediate
    for (int t = 0; t < 8; t++) begin
      f1 = pick_nib();
      imm = pick_nib();
      if (t % 2 == 0) run_cmd("set bit", OP_SET_BIT, REG_A, REG_A, REG_A, f1, f1, imm);
      else run_cmd("reset bit", OP_RST_BIT, REG_A, REG_A, REG_A, f1, f1, imm);
    end

    // full 16 nibble command, the read right behind it sees the result
    load_random();
    bus_cycle(1'b1, CMD, cmd_word(OP_ADD, REG_D, REG_A, REG_B, 4'd5, 4'd4, 4'h0), rdat, edges);
    check_latency("long add", 3 * REG_NIBBLES + 3, edges);
    ref_apply(OP_ADD, REG_D, REG_A, REG_B, 4'd5, 4'd4, 4'h0);
    read_gpr(3, v);
    check_reg("long add read behind", m_gpr[3], v);
    check_state("long add");

    $display("errors: %0d value, %0d timeout", err_value, err_timeout);
    if (err_value == 0 && err_timeout == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+test
hw/saturn_alu_pkg.sv
hw/saturn_bus_pkg.sv
hw/wb_cmd_port.sv
hw/nibble_sequencer.sv
hw/nibble_datapath.sv
hw/working_regs.sv
hw/saturn_alu_top.sv
test/tb_saturn_alu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -Wno-fatal \
  --top-module tb_saturn_alu \
  -f project.f \
  -Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see $LOG"
exit 1
